// File: tlu_controller.f
+incdir+testbench
source/tlu_pkg.sv
source/trigger_input_filter.sv
source/trigger_handshake_fsm.sv
source/event_word_builder.sv
source/tlu_controller.sv
testbench/tlu_controller_tb.sv

// File: testbench/tlu_checks.svh
// typed result checks
`ifndef TLU_CHECKS_SVH
`define TLU_CHECKS_SVH

int error_count   = 0;
int timeout_count = 0; // waits that never completed

task automatic check_word(input string name, input data_word_t actual,
                          input data_word_t expected);
    if (actual !== expected)
    begin
        error_count++;
        $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h at %0t",
                 name, actual, expected, $time);
    end
endtask

task automatic check_count(input string name, input trigger_count_t actual,
                           input trigger_count_t expected);
    if (actual !== expected)
    begin
        error_count++;
        $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h at %0t",
                 name, actual, expected, $time);
    end
endtask

task automatic check_timestamp(input string name, input timestamp_t actual,
                               input timestamp_t expected);
    if (actual !== expected)
    begin
        error_count++;
        $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h at %0t",
                 name, actual, expected, $time);
    end
endtask

task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected)
    begin
        error_count++;
        $display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t",
                 name, actual, expected, $time);
    end
endtask

`endif

// File: testbench/tlu_controller_tb.sv
// TLU controller directed testbench
`timescale 1ns/100ps
`default_nettype none

module tlu_controller_tb
    import tlu_pkg::*;
();

    localparam int CLK_PERIOD      = 8;
    localparam int STIMULUS_CYCLES = 400; // reset plus all tests, rounded up
    localparam int WAIT_LIMIT      = 60;  // cycles to wait for a write or idle
    localparam int TIMESTAMP_GAP   = 30;

    logic           TRIGGER_CLK = 1'b0;
    logic           RESET = 1'b1;
    logic           trigger = 1'b0;
    logic           trigger_veto = 1'b0;
    logic           trigger_enable = 1'b1;
    logic           trigger_acknowledge = 1'b0;
    logic           fifo_acknowledge = 1'b0;
    logic           timestamp_reset_flag = 1'b0;
    logic           tlu_reset_flag = 1'b0;
    logic           tlu_enable_veto = 1'b0;
    logic           trigger_counter_set = 1'b0;
    trigger_count_t trigger_counter_set_value = '0;
    trigger_mode_t  trigger_mode = MODE_EXTERNAL_A;
    data_format_t   conf_data_format = FORMAT_COUNTER;
    cycle_count_t   trigger_threshold = '0;
    cycle_count_t   tlu_accept_wait_cycles = '0;
    cycle_count_t   tlu_low_time_out = '0;
    data_word_t     trigger_data;
    timestamp_t     timestamp;
    logic           trigger_data_write, trigger_accepted_flag;
    logic           fifo_preempt_req, tlu_busy;
    logic           tlu_assert_veto, tlu_low_timeout_error_flag;

    int             cycle = 0;
    int             rise_cycle = 0;   // cycle of the last trigger rising edge
    int             accept_cycle = 0;
    int             write_cycle = 0;
    int             accept_count = 0;
    int             error_pulses = 0;
    trigger_count_t model_count = '0; // expected number of the next trigger
    data_word_t     words[$];         // words seen with trigger_data_write

    `include "tlu_checks.svh"

    tlu_controller DUT (.*);

    always #(CLK_PERIOD / 2) TRIGGER_CLK = ~TRIGGER_CLK;

    always @(posedge TRIGGER_CLK)
        cycle <= cycle + 1;

    // outputs are stable at the falling edge
    always @(negedge TRIGGER_CLK)
    begin
        if (trigger_accepted_flag)
        begin
            accept_cycle = cycle;
            accept_count++;
            check_flag("tlu_busy", tlu_busy, 1'b1); // rises with acceptance
            check_flag("fifo_preempt_req", fifo_preempt_req, 1'b1);
        end
        if (trigger_data_write)
        begin
            write_cycle = cycle;
            words.push_back(trigger_data);
        end
        if (tlu_low_timeout_error_flag)
            error_pulses++;
    end

    initial
    begin
        #(STIMULUS_CYCLES * 2 * CLK_PERIOD);
        timeout_count++;
        $display("the run timed out before all tests finished");
        $display("errors %0d, timeouts %0d", error_count, timeout_count);
        $display("Some tests failed");
        $finish;
    end

    function automatic data_word_t counter_word(input trigger_count_t count);
        return {1'b1, count[WORD_MARKER_BIT-1:0]};
    endfunction

    task automatic tick(input int cycles);
        repeat (cycles) @(posedge TRIGGER_CLK);
    endtask

    task automatic pulse_trigger(input int high_cycles);
        @(posedge TRIGGER_CLK);
        trigger <= 1'b1;
        rise_cycle = cycle;
        tick(high_cycles);
        trigger <= 1'b0;
    endtask

    task automatic wait_write(output data_word_t word);
        int waited;
        word = '0;
        for (waited = 0; waited < WAIT_LIMIT && words.size() == 0; waited++)
            tick(1);
        if (words.size() == 0)
        begin
            timeout_count++;
            $display("no data word was written within %0d cycles", WAIT_LIMIT);
        end
        else
            word = words.pop_front();
    endtask

    // acknowledge pulse, then wait for the FSM to return to idle
    task automatic acknowledge(input logic trigger_ack, input logic fifo_ack);
        int waited;
        @(posedge TRIGGER_CLK);
        trigger_acknowledge <= trigger_ack;
        fifo_acknowledge    <= fifo_ack;
        tick(1);
        trigger_acknowledge <= 1'b0;
        fifo_acknowledge    <= 1'b0;
        @(negedge TRIGGER_CLK);
        for (waited = 0; waited < WAIT_LIMIT && tlu_busy; waited++)
            @(negedge TRIGGER_CLK);
        if (tlu_busy)
        begin
            timeout_count++;
            $display("tlu_busy stayed high after both acknowledges");
        end
        check_flag("fifo_preempt_req", fifo_preempt_req, 1'b0);
        @(posedge TRIGGER_CLK);
    endtask

    // one accepted trigger with write, busy and acknowledge
    task automatic run_trigger(input int high_cycles, input logic check_latency,
                               output data_word_t word);
        pulse_trigger(high_cycles);
        wait_write(word);
        if (check_latency)
            check_count("write latency", write_cycle - accept_cycle, 1);
        repeat (3)
        begin
            @(negedge TRIGGER_CLK);
            check_flag("tlu_busy", tlu_busy, 1'b1);
            check_flag("fifo_preempt_req", fifo_preempt_req, 1'b1);
        end
        acknowledge(1'b1, 1'b1);
        model_count++;
    endtask

    task automatic test_after_reset();
        @(negedge TRIGGER_CLK);
        check_flag("trigger_data_write", trigger_data_write, 1'b0);
        check_flag("trigger_accepted_flag", trigger_accepted_flag, 1'b0);
        check_flag("tlu_busy", tlu_busy, 1'b0);
        check_flag("fifo_preempt_req", fifo_preempt_req, 1'b0);
        check_flag("tlu_assert_veto", tlu_assert_veto, 1'b0);
        check_word("trigger_data", trigger_data, '0);
        @(posedge TRIGGER_CLK);
    endtask

    task automatic test_external_counter();
        data_word_t word;
        data_word_t expected;
        trigger_counter_set       <= 1'b1;
        trigger_counter_set_value <= 32'hc000_0ffe; // top bit is dropped from the word
        tick(1);
        trigger_counter_set <= 1'b0;
        model_count = 32'hc000_0ffe;
        repeat (3)
        begin
            expected = counter_word(model_count);
            run_trigger(2, 1'b1, word);
            check_word("trigger_data", word, expected);
        end
    endtask

    task automatic test_threshold_veto();
        data_word_t word;
        data_word_t expected;
        trigger_threshold <= 8'd4;
        pulse_trigger(2); // glitch below threshold
        tick(12);
        check_count("writes after short pulse", words.size(), 0);
        expected = counter_word(model_count);
        run_trigger(10, 1'b1, word);
        check_word("trigger_data", word, expected);
        trigger_threshold <= 8'd0;
        trigger_veto      <= 1'b1;
        pulse_trigger(2);
        tick(12);
        check_count("writes while vetoed", words.size(), 0);
        trigger_veto <= 1'b0;
        expected = counter_word(model_count);
        run_trigger(2, 1'b1, word);
        check_word("trigger_data", word, expected);
    endtask

    task automatic test_timestamp_formats();
        data_word_t     first;
        data_word_t     second;
        data_word_t     expected;
        trigger_count_t last_count;
        timestamp_t     second_stamp;
        int             start_cycle;
        int             reset_cycle;
        conf_data_format     <= FORMAT_TIMESTAMP;
        timestamp_reset_flag <= 1'b1;
        tick(1);
        timestamp_reset_flag <= 1'b0;
        reset_cycle = cycle; // counter restarts from zero on this edge
        @(negedge TRIGGER_CLK);
        check_timestamp("timestamp", timestamp, '0);
        tick(2);
        start_cycle = cycle;
        run_trigger(2, 1'b1, first);
        while (cycle < start_cycle + TIMESTAMP_GAP)
            tick(1);
        run_trigger(2, 1'b1, second); // rising edges TIMESTAMP_GAP apart
        second_stamp = rise_cycle - reset_cycle; // cycles counted up to the edge
        check_timestamp("timestamp difference", second[30:0] - first[30:0], TIMESTAMP_GAP);
        check_flag("trigger_data marker", second[WORD_MARKER_BIT], 1'b1);
        last_count = model_count - 1;
        conf_data_format <= FORMAT_COMBINED;
        expected = {1'b1, second_stamp[COMBINED_TIMESTAMP_BITS-1:0],
                    last_count[COMBINED_COUNT_BITS-1:0]};
        @(negedge TRIGGER_CLK);
        check_word("trigger_data", trigger_data, expected);
        @(posedge TRIGGER_CLK);
        conf_data_format <= FORMAT_COUNTER;
    endtask

    task automatic test_tlu_mode();
        data_word_t word;
        data_word_t expected;
        trigger_mode     <= MODE_TLU_HANDSHAKE;
        tlu_low_time_out <= 8'd12;
        expected = counter_word(model_count);
        run_trigger(5, 1'b0, word);
        check_word("trigger_data", word, expected);
        check_flag("write after trigger low", (write_cycle - accept_cycle) >= 5, 1'b1);
        tick(5);
        check_count("extra writes", words.size(), 0);
        check_count("low timeout pulses", error_pulses, 0);
        // held well past the low timeout
        expected = counter_word(model_count);
        trigger <= 1'b1;
        wait_write(word);
        check_word("trigger_data", word, expected);
        acknowledge(1'b1, 1'b1);
        model_count++;
        tick(10);
        trigger <= 1'b0;
        tick(10);
        check_count("low timeout pulses", error_pulses, 1);
        check_count("extra writes", words.size(), 0);
        trigger_enable  <= 1'b0;
        tlu_enable_veto <= 1'b1;
        tick(2);
        @(negedge TRIGGER_CLK);
        check_flag("tlu_assert_veto", tlu_assert_veto, 1'b1);
        @(posedge TRIGGER_CLK);
        trigger_mode    <= MODE_EXTERNAL_A;
        trigger_enable  <= 1'b1;
        tlu_enable_veto <= 1'b0;
        tick(2);
    endtask

    task automatic test_back_pressure();
        data_word_t word;
        data_word_t expected;
        int         accepts_before;
        int         i;
        expected = counter_word(model_count);
        pulse_trigger(2);
        wait_write(word);
        check_word("trigger_data", word, expected);
        model_count++;
        trigger_acknowledge <= 1'b1; // FIFO side stays silent
        tick(1);
        trigger_acknowledge <= 1'b0;
        accepts_before = accept_count;
        for (i = 0; i < 20; i++)
        begin
            @(negedge TRIGGER_CLK);
            check_flag("tlu_busy", tlu_busy, 1'b1);
            check_flag("fifo_preempt_req", fifo_preempt_req, 1'b1);
            @(posedge TRIGGER_CLK);
            trigger <= (i >= 6) && (i < 9);
        end
        check_count("acceptances while busy", accept_count - accepts_before, 0);
        acknowledge(1'b0, 1'b1);
        expected = counter_word(model_count);
        run_trigger(2, 1'b1, word);
        check_word("trigger_data", word, expected);
    endtask

    initial
    begin
        tick(16);
        RESET <= 1'b0;
        test_after_reset();
        test_external_counter();
        test_threshold_veto();
        test_timestamp_formats();
        test_tlu_mode();
        test_back_pressure();
        tick(4);
        $display("errors %0d, timeouts %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/tlu_controller.sv
// trigger logic unit controller top
`timescale 1ns/100ps
`default_nettype none

module tlu_controller
    import tlu_pkg::*;
(
    input  logic           TRIGGER_CLK,
    input  logic           RESET,
    input  logic           trigger,
    input  logic           trigger_veto,
    input  logic           trigger_enable,
    input  logic           trigger_acknowledge,
    input  logic           fifo_acknowledge,
    input  logic           timestamp_reset_flag,
    input  logic           tlu_reset_flag,
    input  logic           tlu_enable_veto,
    input  logic           trigger_counter_set,
    input  trigger_count_t trigger_counter_set_value,
    input  trigger_mode_t  trigger_mode,
    input  data_format_t   conf_data_format,
    input  cycle_count_t   trigger_threshold,
    input  cycle_count_t   tlu_accept_wait_cycles,
    input  cycle_count_t   tlu_low_time_out,
    output data_word_t     trigger_data,
    output timestamp_t     timestamp,
    output logic           trigger_data_write,
    output logic           trigger_accepted_flag,
    output logic           fifo_preempt_req,
    output logic           tlu_busy,
    output logic           tlu_assert_veto,
    output logic           tlu_low_timeout_error_flag
);

    logic trigger_rise;
    logic trigger_qualified;
    logic idle;
    logic timestamp_latch;

    trigger_input_filter u_filter (
        .TRIGGER_CLK            (TRIGGER_CLK),
        .RESET                  (RESET),
        .trigger                (trigger),
        .trigger_enable         (trigger_enable),
        .idle                   (idle),
        .trigger_mode           (trigger_mode),
        .trigger_threshold      (trigger_threshold),
        .tlu_accept_wait_cycles (tlu_accept_wait_cycles),
        .trigger_rise           (trigger_rise),
        .trigger_qualified      (trigger_qualified)
    );

    trigger_handshake_fsm u_fsm (
        .TRIGGER_CLK                (TRIGGER_CLK),
        .RESET                      (RESET),
        .trigger                    (trigger),
        .trigger_enable             (trigger_enable),
        .trigger_veto               (trigger_veto),
        .trigger_acknowledge        (trigger_acknowledge),
        .fifo_acknowledge           (fifo_acknowledge),
        .trigger_rise               (trigger_rise),
        .trigger_qualified          (trigger_qualified),
        .tlu_enable_veto            (tlu_enable_veto),
        .trigger_mode               (trigger_mode),
        .tlu_low_time_out           (tlu_low_time_out),
        .idle                       (idle),
        .timestamp_latch            (timestamp_latch),
        .trigger_accepted_flag      (trigger_accepted_flag),
        .trigger_data_write         (trigger_data_write),
        .fifo_preempt_req           (fifo_preempt_req),
        .tlu_busy                   (tlu_busy),
        .tlu_assert_veto            (tlu_assert_veto),
        .tlu_low_timeout_error_flag (tlu_low_timeout_error_flag)
    );

    event_word_builder u_word (
        .TRIGGER_CLK               (TRIGGER_CLK),
        .RESET                     (RESET),
        .timestamp_latch           (timestamp_latch),
        .trigger_accepted_flag     (trigger_accepted_flag),
        .timestamp_reset_flag      (timestamp_reset_flag),
        .tlu_reset_flag            (tlu_reset_flag),
        .trigger_counter_set       (trigger_counter_set),
        .trigger_counter_set_value (trigger_counter_set_value),
        .trigger_mode              (trigger_mode),
        .conf_data_format          (conf_data_format),
        .timestamp                 (timestamp),
        .trigger_data              (trigger_data)
    );

endmodule

`default_nettype wire

// File: source/event_word_builder.sv
// timestamp, trigger counter and data word
`timescale 1ns/100ps
`default_nettype none

module event_word_builder
    import tlu_pkg::*;
(
    input  logic           TRIGGER_CLK,
    input  logic           RESET,
    input  logic           timestamp_latch,
    input  logic           trigger_accepted_flag,
    input  logic           timestamp_reset_flag,
    input  logic           tlu_reset_flag,
    input  logic           trigger_counter_set,
    input  trigger_count_t trigger_counter_set_value,
    input  trigger_mode_t  trigger_mode,
    input  data_format_t   conf_data_format,
    output timestamp_t     timestamp,
    output data_word_t     trigger_data
);

    trigger_count_t trigger_counter;
    timestamp_t     captured_timestamp;
    trigger_count_t captured_count;
    logic           word_marker; // set once a trigger has been taken
    logic           tlu_mode;
    data_word_t     word;

    assign tlu_mode = (trigger_mode == MODE_TLU_HANDSHAKE) ||
                      (trigger_mode == MODE_TLU_NUMBER);

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET || timestamp_reset_flag || (tlu_reset_flag && tlu_mode))
            timestamp <= '0;
        else
            timestamp <= timestamp + 32'd1;
    end

    // preset wins over increment
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
            trigger_counter <= '0;
        else if (trigger_counter_set)
            trigger_counter <= trigger_counter_set_value;
        else if (trigger_accepted_flag)
            trigger_counter <= trigger_counter + 32'd1;
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            captured_timestamp <= '0;
            captured_count     <= '0;
            word_marker        <= 1'b0;
        end
        else
        begin
            if (timestamp_latch)
                captured_timestamp <= timestamp;
            if (trigger_accepted_flag)
            begin
                captured_count <= trigger_counter; // value before increment
                word_marker    <= 1'b1;
            end
        end
    end

    always_comb
    begin
        word = '0;
        case (conf_data_format)
            FORMAT_TIMESTAMP:
                word[WORD_MARKER_BIT-1:0] = captured_timestamp[WORD_MARKER_BIT-1:0];
            FORMAT_COMBINED:
                word[WORD_MARKER_BIT-1:0] = {captured_timestamp[COMBINED_TIMESTAMP_BITS-1:0],
                                             captured_count[COMBINED_COUNT_BITS-1:0]};
            default:
                word[WORD_MARKER_BIT-1:0] = captured_count[WORD_MARKER_BIT-1:0];
        endcase
        word[WORD_MARKER_BIT] = word_marker;
    end

    assign trigger_data = word;

endmodule

`default_nettype wire

// File: source/trigger_handshake_fsm.sv
// trigger acceptance and handshake FSM
`timescale 1ns/100ps
`default_nettype none

module trigger_handshake_fsm
    import tlu_pkg::*;
(
    input  logic          TRIGGER_CLK,
    input  logic          RESET,
    input  logic          trigger,
    input  logic          trigger_enable,
    input  logic          trigger_veto,
    input  logic          trigger_acknowledge,
    input  logic          fifo_acknowledge,
    input  logic          trigger_rise,
    input  logic          trigger_qualified,
    input  logic          tlu_enable_veto,
    input  trigger_mode_t trigger_mode,
    input  cycle_count_t  tlu_low_time_out,
    output logic          idle,
    output logic          timestamp_latch,
    output logic          trigger_accepted_flag,
    output logic          trigger_data_write,
    output logic          fifo_preempt_req,
    output logic          tlu_busy,
    output logic          tlu_assert_veto,
    output logic          tlu_low_timeout_error_flag
);

    handshake_state_e state;
    handshake_state_e next_state;

    logic         external_mode;
    logic         tlu_mode;
    logic         acknowledge_pending; // either ack input still high
    logic         trigger_acked;
    logic         fifo_acked;
    cycle_count_t low_count;
    logic         low_timeout_error;
    logic         low_timeout_error_next;

    assign external_mode = (trigger_mode == MODE_EXTERNAL_A) ||
                           (trigger_mode == MODE_EXTERNAL_B);
    assign tlu_mode      = (trigger_mode == MODE_TLU_HANDSHAKE) ||
                           (trigger_mode == MODE_TLU_NUMBER);

    assign acknowledge_pending = trigger_acknowledge | fifo_acknowledge;

    assign idle            = (state == IDLE);
    assign timestamp_latch = idle & trigger_rise; // stamp closest to the edge

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                if (!acknowledge_pending && trigger_enable && trigger_qualified)
                begin
                    if (external_mode && !trigger_veto)
                        next_state = SEND_COMMAND;
                    else if (tlu_mode)
                        next_state = WAIT_TRIGGER_LOW; // TLU owns its own veto
                end
            end
            SEND_COMMAND:
            begin
                next_state = LATCH_DATA;
            end
            WAIT_TRIGGER_LOW:
            begin
                if (!trigger || low_timeout_error)
                    next_state = LATCH_DATA;
            end
            LATCH_DATA:
            begin
                next_state = WAIT_ACKNOWLEDGE;
            end
            WAIT_ACKNOWLEDGE:
            begin
                if (trigger_acked && fifo_acked)
                    next_state = IDLE;
            end
            default:
            begin
                next_state = IDLE;
            end
        endcase
    end

    // trigger stuck high in handshake
    assign low_timeout_error_next = (next_state == WAIT_TRIGGER_LOW) &&
                                    (tlu_low_time_out != '0) &&
                                    (low_count >= tlu_low_time_out);

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            low_count                  <= '0;
            low_timeout_error          <= 1'b0;
            tlu_low_timeout_error_flag <= 1'b0;
        end
        else
        begin
            if (next_state != WAIT_TRIGGER_LOW)
                low_count <= '0;
            else if (low_count != '1)
                low_count <= low_count + 8'd1;
            low_timeout_error          <= low_timeout_error_next;
            tlu_low_timeout_error_flag <= low_timeout_error_next & ~low_timeout_error;
        end
    end

    // acknowledges may come in any order, any time after acceptance
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            trigger_acked <= 1'b0;
            fifo_acked    <= 1'b0;
        end
        else if (next_state == IDLE)
        begin
            trigger_acked <= 1'b0;
            fifo_acked    <= 1'b0;
        end
        else
        begin
            if (trigger_acknowledge)
                trigger_acked <= 1'b1;
            if (fifo_acknowledge)
                fifo_acked <= 1'b1;
        end
    end

    // outputs follow the next state
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            trigger_accepted_flag <= 1'b0;
            trigger_data_write    <= 1'b0;
            fifo_preempt_req      <= 1'b0;
            tlu_busy              <= 1'b0;
            tlu_assert_veto       <= 1'b0;
        end
        else
        begin
            trigger_accepted_flag <= (state == IDLE) && (next_state != IDLE);
            trigger_data_write    <= (next_state == LATCH_DATA);
            fifo_preempt_req      <= (next_state != IDLE);
            tlu_busy              <= (next_state != IDLE);
            // only outside a running handshake
            tlu_assert_veto       <= (next_state == IDLE) && tlu_enable_veto && tlu_mode &&
                                     (!trigger_enable || trigger_veto);
        end
    end

endmodule

`default_nettype wire

// File: source/trigger_input_filter.sv
// trigger edge and glitch filter
`timescale 1ns/100ps
`default_nettype none

module trigger_input_filter
    import tlu_pkg::*;
(
    input  logic          TRIGGER_CLK,
    input  logic          RESET,
    input  logic          trigger,
    input  logic          trigger_enable,
    input  logic          idle,
    input  trigger_mode_t trigger_mode,
    input  cycle_count_t  trigger_threshold,
    input  cycle_count_t  tlu_accept_wait_cycles,
    output logic          trigger_rise,
    output logic          trigger_qualified
);

    logic         trigger_ff;
    logic         enable_ff;
    logic         enable_rise;
    logic         external_mode;
    logic         counting;
    cycle_count_t high_count;
    logic         threshold_reached;   // external mode, long enough pulse
    logic         accept_wait_reached; // TLU mode, long enough pulse

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            trigger_ff <= 1'b0;
            enable_ff  <= 1'b0;
        end
        else
        begin
            trigger_ff <= trigger;
            enable_ff  <= trigger_enable;
        end
    end

    assign trigger_rise  = trigger & ~trigger_ff;
    assign enable_rise   = trigger_enable & ~enable_ff;
    assign external_mode = (trigger_mode == MODE_EXTERNAL_A) ||
                           (trigger_mode == MODE_EXTERNAL_B);
    assign counting      = idle & trigger_enable;

    // consecutive high cycles, started only by a rising edge
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
            high_count <= '0;
        else if (!counting)
            high_count <= '0;
        else if (high_count == '0)
            high_count <= trigger_rise ? 8'd1 : 8'd0;
        else if (!trigger)
            high_count <= '0; // glitch ended early
        else if (high_count != HIGH_COUNT_MAX)
            high_count <= high_count + 8'd1;
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            threshold_reached   <= 1'b0;
            accept_wait_reached <= 1'b0;
        end
        else
        begin
            threshold_reached   <= counting && (trigger_threshold != '0) &&
                                   (high_count >= trigger_threshold);
            accept_wait_reached <= counting && (tlu_accept_wait_cycles != '0) &&
                                   (high_count >= tlu_accept_wait_cycles);
        end
    end

    // acceptance condition for the current mode
    always_comb
    begin
        if (external_mode)
        begin
            if (trigger_threshold == '0)
                trigger_qualified = trigger_rise;
            else
                trigger_qualified = threshold_reached;
        end
        else if (tlu_accept_wait_cycles == '0)
        begin
            // TLU may already hold trigger high when we get enabled
            trigger_qualified = trigger_rise | (trigger & enable_rise);
        end
        else
        begin
            trigger_qualified = accept_wait_reached;
        end
    end

endmodule

`default_nettype wire

// File: source/tlu_pkg.sv
// trigger logic unit shared types
`default_nettype none

package tlu_pkg;

    typedef logic [31:0] timestamp_t;     // free-running cycle count
    typedef logic [31:0] trigger_count_t; // internal trigger number
    typedef logic [31:0] data_word_t;     // one word per trigger
    typedef logic [7:0]  cycle_count_t;   // config counts and high-time counter
    typedef logic [1:0]  trigger_mode_t;
    typedef logic [1:0]  data_format_t;

    // trigger modes
    localparam trigger_mode_t MODE_EXTERNAL_A    = 2'd0;
    localparam trigger_mode_t MODE_EXTERNAL_B    = 2'd1;
    localparam trigger_mode_t MODE_TLU_HANDSHAKE = 2'd2;
    localparam trigger_mode_t MODE_TLU_NUMBER    = 2'd3; // runs as handshake

    // word formats, format 3 falls back to counter
    localparam data_format_t FORMAT_COUNTER   = 2'd0;
    localparam data_format_t FORMAT_TIMESTAMP = 2'd1;
    localparam data_format_t FORMAT_COMBINED  = 2'd2;

    // combined format field widths
    localparam int COMBINED_TIMESTAMP_BITS = 15;
    localparam int COMBINED_COUNT_BITS     = 16;

    // top bit of every written word
    localparam int WORD_MARKER_BIT = 31;

    // high-time counter saturation
    localparam cycle_count_t HIGH_COUNT_MAX = 8'd255;

    // acceptance and handshake sequence
    typedef enum logic [2:0] {
        IDLE,
        SEND_COMMAND,      // external trigger, no wait for low
        WAIT_TRIGGER_LOW,  // TLU handshake, trigger held by TLU
        LATCH_DATA,
        WAIT_ACKNOWLEDGE
    } handshake_state_e;

endpackage

`default_nettype wire
